// ==== Makefile ====
# Verilator build and run of the predefined table buffer testbench

SRCS := $(filter-out +%,$(shell cat files.f))

obj_dir/Vpredef_buf_tb: files.f $(SRCS) source/predef_defines.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		-f files.f --top-module predef_buf_tb

run: obj_dir/Vpredef_buf_tb
	./obj_dir/Vpredef_buf_tb | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== files.f ====
+incdir+source
source/huff_types_pkg.sv
source/predef_bus_pkg.sv
source/table_ram.sv
source/bank_writer.sv
source/read_sequencer.sv
source/prefetch_queue.sv
source/bit_unpacker.sv
source/predef_buf_top.sv
tests/predef_buf_tb.sv

// ==== tests/predef_buf_tb.sv ====
/*
 * Testbench for the predefined Huffman table buffer.
 * Loads random five-word tables, requests short and long parts, rebuilds
 * the bit stream on the consumer side and compares it with the stored
 * words. Directed tests run in sequence and share the bank state.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module predef_buf_tb import huff_types_pkg::*, predef_bus_pkg::*; ();

   localparam int SHORT_BITS = `N_SHORT_SYMS * `BL_WIDTH;
   localparam int LONG_BITS  = `N_LONG_SYMS * `BL_WIDTH;

   logic        clk;
   logic        rst_n;
   logic        beat_valid;
   table_beat_t beat;
   logic        beat_ready;
   logic        req_valid;
   bl_req_t     req;
   logic        req_ready;
   rsp_cnt_t    bits_avail;
   rsp_bits_t   bits_data;
   rsp_cnt_t    bits_consume;
   logic        bl_done;
   logic        stall_strobe;

   dp_word_t tables [4][`TABLE_WORDS];   // reference tables
   bit       got_q [$];                  // bits taken by the consumer
   integer   seed;
   int       test_errs;
   int       errors;
   int       tests_run;
   int       tests_failed;

   predef_buf_top i_dut (.*);

   always #2 clk = ~clk;

   // ==================================================
   // ingress, request and release
   // ==================================================
   task automatic send_beat(input dp_word_t data, input logic last, input string name);
      int waited;
      waited = 0;
      @(posedge clk);
      beat_valid <= 1'b1;
      beat       <= '{data: data, last: last, trace: 1'b0};
      do begin
         @(negedge clk);
         waited++;
      end while (!beat_ready && waited < 50);
      assert (beat_ready) else begin
         $display("%s: timeout waiting for beat_ready", name);
         test_errs++;
      end
      @(posedge clk);
      beat_valid <= 1'b0;
   endtask

   task automatic load_table(input int t, input string name);
      for (int w = 0; w < `TABLE_WORDS; w++)
         send_beat(tables[t][w], w == `TABLE_WORDS - 1, name);
   endtask

   task automatic send_req(input logic ll, input num_bl_t num, input string name);
      int waited;
      waited = 0;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= '{ll: ll, num_bl: num};
      do begin
         @(negedge clk);
         waited++;
      end while (!req_ready && waited < 50);
      assert (req_ready) else begin
         $display("%s: timeout waiting for req_ready", name);
         test_errs++;
      end
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   task automatic release_bank();
      @(posedge clk);
      bl_done <= 1'b1;
      @(posedge clk);
      bl_done <= 1'b0;
   endtask

   // ==================================================
   // consumer side
   // ==================================================
   // only takes bits already seen and not yet consumed
   task automatic read_stream(input int nbits, input bit random_mode, input string name);
      int take;
      int next;
      int avail;
      int idle;
      int pause;
      take  = 0;
      idle  = 0;
      pause = 0;
      got_q.delete();
      forever begin
         @(negedge clk);
         avail = int'(bits_avail);
         assert (avail <= `MAX_RSP_BITS) else begin
            $display("mismatch %s: bits_avail expected <= %0d actual %0d",
                     name, `MAX_RSP_BITS, avail);
            test_errs++;
         end
         for (int i = 0; i < take; i++)
            got_q.push_back(bits_data[i]);
         if (got_q.size() >= nbits)
            break;
         next = avail - take;
         if (next > nbits - got_q.size())
            next = nbits - got_q.size();
         idle = (next == 0) ? idle + 1 : 0;   // starved cycles
         assert (idle <= 60) else begin
            $display("%s: stream stalled after %0d of %0d bits", name, got_q.size(), nbits);
            test_errs++;
         end
         if (idle > 60)
            break;
         if (random_mode) begin
            if (pause > 0) begin
               pause--;
               next = 0;
            end else if ($unsigned($random(seed)) % 8 == 0) begin
               pause = 5 + $unsigned($random(seed)) % 20;   // long zero run
               next  = 0;
            end else begin
               next = $unsigned($random(seed)) % (next + 1);
            end
         end
         @(posedge clk);
         bits_consume <= rsp_cnt_t'(next);
         take = next;
      end
      @(posedge clk);
      bits_consume <= '0;
   endtask

   task automatic check_stream(input string name, input int t, input int first, input int nbits);
      dp_word_t got_w;
      dp_word_t exp_w;
      int       n;
      assert (got_q.size() == nbits) else begin
         $display("%s: stream ended after %0d of %0d bits", name, got_q.size(), nbits);
         test_errs++;
      end
      for (int k = 0; k * `DP_WIDTH < got_q.size(); k++) begin
         n = got_q.size() - k * `DP_WIDTH;
         if (n > `DP_WIDTH)
            n = `DP_WIDTH;
         got_w = '0;
         for (int b = 0; b < n; b++)
            got_w[b] = got_q[k * `DP_WIDTH + b];   // lsb first
         exp_w = tables[t][first + k];
         if (n < `DP_WIDTH)
            exp_w = exp_w & ((dp_word_t'(1) << n) - dp_word_t'(1));
         assert (got_w == exp_w) else begin
            $display("mismatch %s: word %0d expected %h actual %h", name, first + k, exp_w, got_w);
            test_errs++;
         end
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errs == 0) begin
         $display("%-16s ok", name);
      end else begin
         tests_failed++;
         errors += test_errs;
         $display("%-16s failed with %0d errors", name, test_errs);
      end
   endtask

   // ==================================================
   // directed tests
   // ==================================================
   task automatic short_part_read();
      test_errs = 0;
      load_table(0, "short_read");
      send_req(1'b0, num_bl_t'(`N_SHORT_SYMS), "short_read");
      read_stream(SHORT_BITS, 1'b0, "short_read");
      check_stream("short_read", 0, 0, SHORT_BITS);
      @(negedge clk);
      assert (bits_avail == '0) else begin
         $display("mismatch short_read: bits_avail expected 0 actual %0d", bits_avail);
         test_errs++;
      end
      end_test("short_read");
   endtask

   task automatic long_part_read();
      test_errs = 0;
      send_req(1'b1, num_bl_t'(`N_LONG_SYMS), "long_read");
      read_stream(LONG_BITS, 1'b0, "long_read");
      check_stream("long_read", 0, `LL_OFFSET, LONG_BITS);
      end_test("long_read");
   endtask

   task automatic bank_fill_release();
      int waited;
      test_errs = 0;
      waited    = 0;
      release_bank();                     // first table done
      load_table(1, "bank_fill");
      load_table(2, "bank_fill");
      @(posedge clk);
      beat_valid <= 1'b1;
      beat       <= '{data: tables[3][0], last: 1'b0, trace: 1'b0};
      repeat (8) begin
         @(negedge clk);
         assert (!beat_ready) else begin
            $display("mismatch bank_fill: beat_ready expected 0 actual 1");
            test_errs++;
         end
      end
      release_bank();
      do begin
         @(negedge clk);
         waited++;
      end while (!beat_ready && waited < 20);
      assert (beat_ready) else begin
         $display("bank_fill: beat_ready did not rise after bl_done");
         test_errs++;
      end
      @(posedge clk);
      beat_valid <= 1'b0;
      for (int w = 1; w < `TABLE_WORDS; w++)
         send_beat(tables[3][w], w == `TABLE_WORDS - 1, "bank_fill");
      send_req(1'b0, num_bl_t'(`N_SHORT_SYMS), "bank_fill");
      read_stream(SHORT_BITS, 1'b0, "bank_fill");
      check_stream("bank_fill", 2, 0, SHORT_BITS);
      end_test("bank_fill");
   endtask

   // both banks are full here
   task automatic blocked_beat_strobe();
      test_errs = 0;
      @(posedge clk);
      beat_valid <= 1'b1;
      beat       <= '{data: tables[3][0], last: 1'b0, trace: 1'b1};
      @(negedge clk);
      assert (!beat_ready && !stall_strobe) else begin
         $display("mismatch stall_strobe: ready/strobe expected 0/0 actual %b/%b",
                  beat_ready, stall_strobe);
         test_errs++;
      end
      @(posedge clk);
      beat.trace <= 1'b0;
      @(negedge clk);
      assert (stall_strobe) else begin
         $display("mismatch stall_strobe: strobe expected 1 actual 0");
         test_errs++;
      end
      @(posedge clk);
      beat_valid <= 1'b0;
      repeat (3) begin
         @(negedge clk);
         assert (!stall_strobe) else begin
            $display("mismatch stall_strobe: strobe expected 0 actual 1");
            test_errs++;
         end
      end
      end_test("stall_strobe");
   endtask

   task automatic random_consume_read();
      test_errs = 0;
      send_req(1'b1, num_bl_t'(`N_LONG_SYMS), "back_pressure");
      read_stream(LONG_BITS, 1'b1, "back_pressure");
      check_stream("back_pressure", 2, `LL_OFFSET, LONG_BITS);
      end_test("back_pressure");
   endtask

   task automatic partial_request_clear();
      test_errs = 0;
      send_req(1'b0, num_bl_t'(5), "partial_clear");
      read_stream(5 * `BL_WIDTH, 1'b0, "partial_clear");
      check_stream("partial_clear", 2, 0, 5 * `BL_WIDTH);
      send_req(1'b1, num_bl_t'(`N_LONG_SYMS), "partial_clear");   // rest left unread
      read_stream(LONG_BITS, 1'b0, "partial_clear");
      check_stream("partial_clear", 2, `LL_OFFSET, LONG_BITS);
      end_test("partial_clear");
   endtask

   initial begin
      seed         = 32'h65ea_a103;
      clk          = 1'b0;
      rst_n        = 1'b0;
      beat_valid   = 1'b0;
      beat         = '0;
      req_valid    = 1'b0;
      req          = '0;
      bits_consume = '0;
      bl_done      = 1'b0;
      test_errs    = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int t = 0; t < 4; t++)
         for (int w = 0; w < `TABLE_WORDS; w++)
            tables[t][w] = {$random(seed), $random(seed)};
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      short_part_read();
      long_part_read();
      bank_fill_release();
      blocked_beat_strobe();
      random_consume_read();
      partial_request_clear();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== source/predef_buf_top.sv ====
/*
 * Predefined Huffman code-length table buffer.
 * Tables stream in as 64-bit beats into a ping-pong pair of banks; a
 * consumer requests the short or long part of the current table and
 * reads it back as a bit stream, then releases the bank with bl_done.
 */
`timescale 1ns/1ns

module predef_buf_top import huff_types_pkg::*, predef_bus_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        beat_valid,
   input  table_beat_t beat,
   output logic        beat_ready,
   input  logic        req_valid,
   input  bl_req_t     req,
   output logic        req_ready,
   output rsp_cnt_t    bits_avail,
   output rsp_bits_t   bits_data,
   input  rsp_cnt_t    bits_consume,
   input  logic        bl_done,
   output logic        stall_strobe
);

   bank_ptr_t wr_bank;
   bank_ptr_t rd_bank;
   logic      wr_en;
   buf_addr_t wr_addr;
   dp_word_t  wr_data;
   logic      rd_en;
   buf_addr_t rd_addr;
   dp_word_t  rd_data;
   logic      rd_data_valid;
   logic      clear;       // request accepted
   logic      q_not_empty;
   dp_word_t  q_head;
   logic      word_take;

   // ==================================================
   // write and read control
   // ==================================================
   bank_writer i_writer (
      .clk, .rst_n, .beat_valid, .beat, .beat_ready, .rd_bank, .wr_bank,
      .wr_en, .wr_addr, .wr_data, .stall_strobe
   );

   read_sequencer i_seq (
      .clk, .rst_n, .req_valid, .req, .req_ready, .bl_done, .wr_bank, .rd_bank,
      .word_take, .rd_en, .rd_addr, .clear
   );

   table_ram i_ram (
      .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr,
      .rd_data, .rd_data_valid
   );

   // ==================================================
   // read path to the consumer
   // ==================================================
   prefetch_queue i_queue (
      .clk, .rst_n, .clear,
      .push      (rd_data_valid),
      .push_data (rd_data),
      .pop       (word_take),
      .not_empty (q_not_empty),
      .head      (q_head)
   );

   bit_unpacker i_unpack (
      .clk, .rst_n, .clear,
      .word_valid   (q_not_empty),
      .word         (q_head),
      .word_take,
      .bits_consume, .bits_avail, .bits_data
   );

endmodule

// ==== source/bit_unpacker.sv ====
/*
 * Turns 64-bit table words into a bit stream.
 * Up to MAX_RSP_BITS bits are offered each cycle, oldest bit at bit 0.
 * The consumer removes any number of them; a new word is appended
 * once the bits left would drop below the output width.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module bit_unpacker import huff_types_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      clear,
   input  logic      word_valid,
   input  dp_word_t  word,
   output logic      word_take,
   input  rsp_cnt_t  bits_consume,
   output rsp_cnt_t  bits_avail,
   output rsp_bits_t bits_data
);

   localparam int RES_W = `DP_WIDTH + `MAX_RSP_BITS - 1;   // 73
   localparam int CNT_W = $clog2(RES_W + 1);

   logic [RES_W-1:0] res_q;
   logic [RES_W-1:0] res_d;
   logic [CNT_W-1:0] cnt_q;    // valid bits in residue
   logic [CNT_W-1:0] cnt_d;
   logic [CNT_W-1:0] rem;      // bits left after consume

   // ==================================================
   // shift out consumed bits, append next word
   // ==================================================
   always_comb begin
      logic [RES_W-1:0] kept;
      rem  = cnt_q - CNT_W'(bits_consume);
      kept = (res_q >> bits_consume) & ~({RES_W{1'b1}} << rem);   // clear stale upper bits
      word_take = word_valid && !clear && (rem <= CNT_W'(`MAX_RSP_BITS - 1));
      res_d = kept;
      cnt_d = rem;
      if (word_take) begin
         res_d = kept | (RES_W'(word) << rem);
         cnt_d = rem + CNT_W'(`DP_WIDTH);
      end
      if (clear)
         cnt_d = '0;
   end

   always_ff @(posedge clk) begin
      res_q <= res_d;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cnt_q <= '0;
      else
         cnt_q <= cnt_d;
   end

   // ==================================================
   // response
   // ==================================================
   always_comb begin
      if (cnt_q > CNT_W'(`MAX_RSP_BITS))
         bits_avail = rsp_cnt_t'(`MAX_RSP_BITS);
      else
         bits_avail = rsp_cnt_t'(cnt_q);
   end

   assign bits_data = res_q[`MAX_RSP_BITS-1:0];

endmodule

// ==== source/prefetch_queue.sv ====
/*
 * Small word queue between the table memory and the bit unpacker.
 * Holds up to PREFETCH_DEPTH words. Clear empties it and drops the
 * words of reads that were already in the memory pipeline.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module prefetch_queue import huff_types_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clear,
   input  logic     push,
   input  dp_word_t push_data,
   input  logic     pop,
   output logic     not_empty,
   output dp_word_t head
);

   localparam int PTR_W = $clog2(`PREFETCH_DEPTH);
   localparam int CNT_W = $clog2(`PREFETCH_DEPTH + 1);
   localparam int DSC_W = $clog2(`RD_LATENCY + 1);

   dp_word_t         slots [`PREFETCH_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] used_q;
   logic [DSC_W-1:0] discard_q;   // cycles of stale arrivals left
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(`PREFETCH_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign not_empty = (used_q != '0);
   assign head      = slots[rd_ptr_q];
   assign do_push   = push && !clear && (discard_q == '0);
   assign do_pop    = pop && not_empty && !clear;

   always_ff @(posedge clk) begin
      if (do_push)
         slots[wr_ptr_q] <= push_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         used_q    <= '0;
         discard_q <= '0;
      end else if (clear) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         used_q    <= '0;
         discard_q <= DSC_W'(`RD_LATENCY - 1);
      end else begin
         if (discard_q != '0)
            discard_q <= discard_q - 1'b1;
         if (do_push)
            wr_ptr_q <= bump(wr_ptr_q);
         if (do_pop)
            rd_ptr_q <= bump(rd_ptr_q);
         used_q <= used_q + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

endmodule

// ==== source/read_sequencer.sv ====
/*
 * Read control for the table buffer.
 * Takes one request at a time for the short or long part of the
 * current bank, works out the start word and the word count, and
 * issues one read per cycle while the prefetch path has room.
 * bl_done releases the bank to the writer.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module read_sequencer import huff_types_pkg::*, predef_bus_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      req_valid,
   input  bl_req_t   req,
   output logic      req_ready,
   input  logic      bl_done,
   input  bank_ptr_t wr_bank,
   output bank_ptr_t rd_bank,
   input  logic      word_take,
   output logic      rd_en,
   output buf_addr_t rd_addr,
   output logic      clear
);

   localparam int CREDIT_W = $clog2(`PREFETCH_DEPTH + 1);

   typedef enum logic {
      ST_IDLE,
      ST_READ
   } seq_state_t;

   seq_state_t          state_q;
   buf_addr_t           rd_addr_q;
   word_cnt_t           words_q;
   bank_ptr_t           rd_bank_q;
   logic [CREDIT_W-1:0] credit_q;   // in flight plus queued

   logic                accept;
   buf_addr_t           base;
   logic [13:0]         bit_total;
   word_cnt_t           req_words;

   // ==================================================
   // request decode
   // ==================================================
   assign base      = rd_bank_q[0] ? buf_addr_t'(`TABLE_WORDS) : '0;
   assign bit_total = 14'(req.num_bl) * 14'(`BL_WIDTH);
   assign req_words = word_cnt_t'((bit_total + 14'(`DP_WIDTH - 1)) / 14'(`DP_WIDTH));

   // only while a complete table sits in the read bank
   assign req_ready = (state_q == ST_IDLE) && req_valid && (wr_bank != rd_bank_q);
   assign accept    = req_ready;
   assign clear     = accept;

   assign rd_en = (state_q == ST_READ) &&
                  ((credit_q < CREDIT_W'(`PREFETCH_DEPTH)) || word_take);

   // ==================================================
   // state, address and word count
   // ==================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= ST_IDLE;
         rd_addr_q <= '0;
         words_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  rd_addr_q <= base + (req.ll ? buf_addr_t'(`LL_OFFSET) : buf_addr_t'(0));
                  words_q   <= req_words;
                  if (req_words != '0)
                     state_q <= ST_READ;
               end
            end
            ST_READ: begin
               if (rd_en) begin
                  rd_addr_q <= rd_addr_q + 1'b1;
                  words_q   <= words_q - 1'b1;
                  if (words_q == word_cnt_t'(1))
                     state_q <= ST_IDLE;   // last read issued
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_q  <= '0;
         rd_bank_q <= '0;
      end else begin
         if (accept)
            credit_q <= '0;   // old words are dropped downstream
         else if (rd_en && !word_take)
            credit_q <= credit_q + 1'b1;
         else if (!rd_en && word_take)
            credit_q <= credit_q - 1'b1;
         if (bl_done)
            rd_bank_q <= rd_bank_q + 1'b1;
      end
   end

   assign rd_addr = rd_addr_q;
   assign rd_bank = rd_bank_q;

endmodule

// ==== source/bank_writer.sv ====
/*
 * Ingress side of the table buffer.
 * Accepts 64-bit beats while a bank is free, writes them at a wrapping
 * address and moves to the other bank on the last beat of a table.
 * A traced beat that finds both banks full raises stall_strobe.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module bank_writer import huff_types_pkg::*, predef_bus_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        beat_valid,
   input  table_beat_t beat,
   output logic        beat_ready,
   input  bank_ptr_t   rd_bank,
   output bank_ptr_t   wr_bank,
   output logic        wr_en,
   output buf_addr_t   wr_addr,
   output dp_word_t    wr_data,
   output logic        stall_strobe
);

   buf_addr_t wr_addr_q;
   bank_ptr_t wr_bank_q;
   logic      live_q;      // low until out of reset
   logic      stall_q;
   logic      accept;

   // both banks full when pointers differ only in bit 1
   assign beat_ready = live_q && ((wr_bank_q ^ rd_bank) != 2'b10);
   assign accept     = beat_valid && beat_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         live_q    <= 1'b0;
         wr_addr_q <= '0;
         wr_bank_q <= '0;
         stall_q   <= 1'b0;
      end else begin
         live_q  <= 1'b1;
         stall_q <= beat_valid && !beat_ready && beat.trace;
         if (accept) begin
            if (wr_addr_q == buf_addr_t'(`BUF_DEPTH - 1))
               wr_addr_q <= '0;
            else
               wr_addr_q <= wr_addr_q + 1'b1;
            if (beat.last)
               wr_bank_q <= wr_bank_q + 1'b1;   // table complete
         end
      end
   end

   assign wr_en        = accept;
   assign wr_addr      = wr_addr_q;
   assign wr_data      = beat.data;
   assign wr_bank      = wr_bank_q;
   assign stall_strobe = stall_q;

endmodule

// ==== source/table_ram.sv ====
/*
 * Two-bank word store for the predefined tables.
 * One write port and one read port. Read data and its valid flag come
 * out two cycles after rd_en: array read register, then output register.
 */
`timescale 1ns/1ns
`include "predef_defines.svh"

module table_ram import huff_types_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wr_en,
   input  buf_addr_t wr_addr,
   input  dp_word_t  wr_data,
   input  logic      rd_en,
   input  buf_addr_t rd_addr,
   output dp_word_t  rd_data,
   output logic      rd_data_valid
);

   dp_word_t mem [`BUF_DEPTH];
   dp_word_t rd_word_q;    // array read stage
   dp_word_t out_word_q;   // output stage
   logic     rd_vld_q;
   logic     out_vld_q;

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      if (rd_en)
         rd_word_q <= mem[rd_addr];
      out_word_q <= rd_word_q;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q  <= 1'b0;
         out_vld_q <= 1'b0;
      end else begin
         rd_vld_q  <= rd_en;
         out_vld_q <= rd_vld_q;
      end
   end

   assign rd_data       = out_word_q;
   assign rd_data_valid = out_vld_q;

endmodule

// ==== source/predef_bus_pkg.sv ====
/*
 * Packed bus payloads on the ports of the table buffer.
 * The ingress beat from the header parser and the request from the
 * Huffman table consumer. Used by the top level and its port blocks.
 */
package predef_bus_pkg;

   import huff_types_pkg::*;

   // ==================================================
   // ingress beat, 66 bits
   // ==================================================
   typedef struct packed {
      dp_word_t data;
      logic     last;    // fifth word of a table
      logic     trace;   // report a stall on this beat
   } table_beat_t;

   // ==================================================
   // table request, 11 bits
   // ==================================================
   typedef struct packed {
      logic    ll;       // long-symbol part
      num_bl_t num_bl;
   } bl_req_t;

endpackage

// ==== source/huff_types_pkg.sv ====
/*
 * Vector types for the table buffer datapath.
 * Words, memory addresses, word counts, bank pointers and the
 * response bit vector and count. Imported by every RTL block.
 */
`include "predef_defines.svh"

package huff_types_pkg;

   // one stored table word
   typedef logic [`DP_WIDTH-1:0]                 dp_word_t;

   typedef logic [$clog2(`BUF_DEPTH)-1:0]         buf_addr_t;     // covers both banks
   typedef logic [$clog2(`TABLE_WORDS+1)-1:0]     word_cnt_t;     // words left in a request

   // low bit picks the bank, bit 1 separates full from empty
   typedef logic [1:0]                            bank_ptr_t;

   typedef logic [`MAX_RSP_BITS-1:0]              rsp_bits_t;     // lsb is oldest bit
   typedef logic [$clog2(`MAX_RSP_BITS+1)-1:0]    rsp_cnt_t;      // 0 to 10

   // symbol count of a request
   typedef logic [9:0]                            num_bl_t;

endpackage

// ==== source/predef_defines.svh ====
/*
 * Shared geometry for the predefined Huffman table buffer.
 * Word width, code-length width, table layout, storage latency and
 * the response width per cycle. Include this wherever a size is needed.
 */
`ifndef PREDEF_DEFINES_SVH
`define PREDEF_DEFINES_SVH

// ==================================================
// data and code lengths
// ==================================================
`define DP_WIDTH        64   // bits per stored word
`define BL_WIDTH        4    // bits per code length
`define N_SHORT_SYMS    32
`define N_LONG_SYMS     48

// ==================================================
// table layout and read path
// ==================================================
`define LL_OFFSET       2    // long part starts at this word
`define TABLE_WORDS     5
`define BUF_DEPTH       10   // two banks
`define RD_LATENCY      2    // rd_en to data
`define PREFETCH_DEPTH  3    // latency plus one
`define MAX_RSP_BITS    10   // bits offered per cycle

`endif
